// ==== source/uart_dbg_pkg.sv ====
// Shared protocol codes, FSM states and bus structs for the UART debug bridge
`default_nettype none

package uart_dbg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Protocol
  ////////////////////////////////////////////////////////////////////////////

  // Byte codes seen on the serial line
  typedef enum logic [7:0] {
    CHR_EOT   = 8'h04,
    CHR_ACK   = 8'h06,
    CMD_READ  = 8'h11,
    CMD_WRITE = 8'h12,
    CMD_EXEC  = 8'h13
  } dbg_byte_e;

  // Address and length fields are 8 bytes, little endian
  localparam int unsigned PROTO_FIELD_BYTES = 8;

  typedef enum logic [3:0] {
    IDLE,
    GET_ADDR,
    GET_LEN,
    SEND_ACK,
    XFER_RX,
    BUS,
    XFER_TX,
    SEND_EOT,
    EXEC
  } dbg_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // Buses and streams
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned WB_ADR_W = 16;

  // Wishbone classic, byte wide
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [7:0]          dat;
  } wb_req_t;

  typedef struct packed {
    logic       ack;
    logic [7:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byte_strm_t;

  typedef struct packed {
    logic        valid;
    logic [63:0] entry;
  } exec_t;

endpackage

`default_nettype wire

// ==== source/uart_rx.sv ====
// 8N1 UART receiver; samples each bit at mid-bit and pulses one byte per good frame
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    rxd_i,
  output uart_dbg_pkg::byte_strm_t byte_o
);

  localparam int unsigned CntW = (ClksPerBit > 2) ? $clog2(ClksPerBit) : 1;
  localparam logic [CntW-1:0] HalfMax = CntW'(ClksPerBit / 2 - 1);
  localparam logic [CntW-1:0] FullMax = CntW'(ClksPerBit - 1);

  logic            rx_meta_q;
  logic            rx_sync_q;
  logic            busy_q;
  logic [3:0]      bit_cnt_q;
  logic [CntW-1:0] clk_cnt_q;
  logic [7:0]      shift_q;
  logic            valid_q;
  logic            sample;

  // Idle line is high, so the synchronizer comes out of reset high
  always_ff @(posedge clk) begin
    if (rst_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rxd_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  // Half a bit to the middle of start, a full bit after that
  assign sample = busy_q && (clk_cnt_q == ((bit_cnt_q == 4'd0) ? HalfMax : FullMax));

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      clk_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!busy_q) begin
        clk_cnt_q <= '0;
        bit_cnt_q <= '0;
        if (!rx_sync_q) begin
          busy_q <= 1'b1;
        end
      end else if (sample) begin
        clk_cnt_q <= '0;
        bit_cnt_q <= bit_cnt_q + 4'd1;
        if (bit_cnt_q == 4'd0) begin
          // Line back high at mid start bit, treat as glitch
          if (rx_sync_q) begin
            busy_q <= 1'b0;
          end
        end else if (bit_cnt_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= rx_sync_q;
        end
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_cnt_q != 4'd0 && bit_cnt_q != 4'd9) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign byte_o = '{valid: valid_q, data: shift_q};

endmodule

`default_nettype wire

// ==== source/uart_tx.sv ====
// 8N1 UART transmitter with valid/ready handshake on the byte input
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                    clk,
  input  logic                    rst_i,
  input  uart_dbg_pkg::byte_strm_t byte_i,
  output logic                    ready_o,
  output logic                    txd_o
);

  localparam int unsigned CntW = (ClksPerBit > 2) ? $clog2(ClksPerBit) : 1;
  localparam logic [CntW-1:0] FullMax = CntW'(ClksPerBit - 1);

  logic            busy_q;
  logic [9:0]      frame_q;
  logic [3:0]      bit_cnt_q;
  logic [CntW-1:0] clk_cnt_q;
  logic            bit_end;

  assign bit_end = busy_q && (clk_cnt_q == FullMax);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      clk_cnt_q <= '0;
    end else if (!busy_q) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= '0;
      if (byte_i.valid) begin
        busy_q <= 1'b1;
      end
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      bit_cnt_q <= bit_cnt_q + 4'd1;
      // End of stop bit frees the transmitter
      if (bit_cnt_q == 4'd9) begin
        busy_q <= 1'b0;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  // Stop, data LSB first, start; shifted out from bit 0
  always_ff @(posedge clk) begin
    if (!busy_q && byte_i.valid) begin
      frame_q <= {1'b1, byte_i.data, 1'b0};
    end else if (bit_end) begin
      frame_q <= {1'b1, frame_q[9:1]};
    end
  end

  assign ready_o = ~busy_q;
  assign txd_o   = busy_q ? frame_q[0] : 1'b1;

endmodule

`default_nettype wire

// ==== source/dbg_cmd_fsm.sv ====
// Debug protocol engine; parses host commands, replies over UART, masters Wishbone
`timescale 1ns/1ps
`default_nettype none

module dbg_cmd_fsm (
  input  logic                     clk,
  input  logic                     rst_i,
  input  uart_dbg_pkg::byte_strm_t rx_byte_i,
  output uart_dbg_pkg::byte_strm_t tx_byte_o,
  input  logic                     tx_ready_i,
  output uart_dbg_pkg::wb_req_t    wb_req_o,
  input  uart_dbg_pkg::wb_rsp_t    wb_rsp_i,
  output uart_dbg_pkg::exec_t      exec_o
);

  localparam int unsigned FieldW  = 8 * uart_dbg_pkg::PROTO_FIELD_BYTES;
  localparam int unsigned HdrCntW = $clog2(uart_dbg_pkg::PROTO_FIELD_BYTES);
  localparam logic [HdrCntW-1:0] HdrLast = HdrCntW'(uart_dbg_pkg::PROTO_FIELD_BYTES - 1);

  uart_dbg_pkg::dbg_state_e state_q;
  uart_dbg_pkg::dbg_byte_e  cmd_q;
  uart_dbg_pkg::dbg_byte_e  rx_code;
  uart_dbg_pkg::wb_req_t    wb_q;

  logic [FieldW-1:0]  addr_q;
  logic [FieldW-1:0]  len_q;
  logic [HdrCntW-1:0] hdr_cnt_q;
  logic               tx_valid_q;
  logic [7:0]         tx_data_q;
  // Read-ahead slot, lets the next bus read overlap the current frame
  logic               ahead_valid_q;
  logic [7:0]         ahead_data_q;
  logic               tx_fire;
  logic               bus_ack;

  assign rx_code = uart_dbg_pkg::dbg_byte_e'(rx_byte_i.data);
  assign tx_fire = tx_valid_q & tx_ready_i;
  assign bus_ack = wb_q.cyc & wb_rsp_i.ack;

  ////////////////////////////////////////////////////////////////////////////
  // Command FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q       <= uart_dbg_pkg::IDLE;
      cmd_q         <= uart_dbg_pkg::CHR_ACK;
      hdr_cnt_q     <= '0;
      tx_valid_q    <= 1'b0;
      ahead_valid_q <= 1'b0;
      wb_q.cyc      <= 1'b0;
      wb_q.stb      <= 1'b0;
      wb_q.we       <= 1'b0;
    end else begin
      if (tx_fire) begin
        tx_valid_q <= 1'b0;
      end
      // Cycle ends right after ack
      if (bus_ack) begin
        wb_q.cyc <= 1'b0;
        wb_q.stb <= 1'b0;
      end
      unique case (state_q)
        uart_dbg_pkg::IDLE: begin
          if (rx_byte_i.valid) begin
            case (rx_code)
              uart_dbg_pkg::CHR_ACK: begin
                cmd_q      <= uart_dbg_pkg::CHR_ACK;
                tx_data_q  <= uart_dbg_pkg::CHR_ACK;
                tx_valid_q <= 1'b1;
                state_q    <= uart_dbg_pkg::SEND_ACK;
              end
              uart_dbg_pkg::CMD_READ, uart_dbg_pkg::CMD_WRITE, uart_dbg_pkg::CMD_EXEC: begin
                cmd_q     <= rx_code;
                hdr_cnt_q <= '0;
                state_q   <= uart_dbg_pkg::GET_ADDR;
              end
              default: ;
            endcase
          end
        end
        uart_dbg_pkg::GET_ADDR: begin
          if (rx_byte_i.valid) begin
            addr_q    <= {rx_byte_i.data, addr_q[FieldW-1:8]};
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HdrLast) begin
              hdr_cnt_q <= '0;
              if (cmd_q == uart_dbg_pkg::CMD_EXEC) begin
                tx_data_q  <= uart_dbg_pkg::CHR_ACK;
                tx_valid_q <= 1'b1;
                state_q    <= uart_dbg_pkg::EXEC;
              end else begin
                state_q <= uart_dbg_pkg::GET_LEN;
              end
            end
          end
        end
        uart_dbg_pkg::GET_LEN: begin
          if (rx_byte_i.valid) begin
            len_q     <= {rx_byte_i.data, len_q[FieldW-1:8]};
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_cnt_q == HdrLast) begin
              tx_data_q  <= uart_dbg_pkg::CHR_ACK;
              tx_valid_q <= 1'b1;
              state_q    <= uart_dbg_pkg::SEND_ACK;
            end
          end
        end
        uart_dbg_pkg::SEND_ACK: begin
          if (tx_fire) begin
            if (cmd_q == uart_dbg_pkg::CHR_ACK) begin
              state_q <= uart_dbg_pkg::IDLE;
            end else if (len_q == '0) begin
              tx_data_q  <= uart_dbg_pkg::CHR_EOT;
              tx_valid_q <= 1'b1;
              state_q    <= uart_dbg_pkg::SEND_EOT;
            end else if (cmd_q == uart_dbg_pkg::CMD_WRITE) begin
              state_q <= uart_dbg_pkg::XFER_RX;
            end else begin
              state_q <= uart_dbg_pkg::XFER_TX;
            end
          end
        end
        uart_dbg_pkg::XFER_RX: begin
          if (rx_byte_i.valid) begin
            wb_q.cyc <= 1'b1;
            wb_q.stb <= 1'b1;
            wb_q.we  <= 1'b1;
            wb_q.adr <= addr_q[uart_dbg_pkg::WB_ADR_W-1:0];
            wb_q.dat <= rx_byte_i.data;
            state_q  <= uart_dbg_pkg::BUS;
          end
        end
        uart_dbg_pkg::BUS: begin
          if (bus_ack) begin
            wb_q.we <= 1'b0;
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            if (len_q == FieldW'(1)) begin
              tx_data_q  <= uart_dbg_pkg::CHR_EOT;
              tx_valid_q <= 1'b1;
              state_q    <= uart_dbg_pkg::SEND_EOT;
            end else begin
              state_q <= uart_dbg_pkg::XFER_RX;
            end
          end
        end
        uart_dbg_pkg::XFER_TX: begin
          // Fetch the next byte once the read-ahead slot is free
          if (!wb_q.cyc && !ahead_valid_q && len_q != '0) begin
            wb_q.cyc <= 1'b1;
            wb_q.stb <= 1'b1;
            wb_q.we  <= 1'b0;
            wb_q.adr <= addr_q[uart_dbg_pkg::WB_ADR_W-1:0];
          end
          if (bus_ack) begin
            ahead_data_q  <= wb_rsp_i.dat;
            ahead_valid_q <= 1'b1;
            addr_q        <= addr_q + 1'b1;
            len_q         <= len_q - 1'b1;
          end
          if (ahead_valid_q && (!tx_valid_q || tx_ready_i)) begin
            tx_data_q     <= ahead_data_q;
            tx_valid_q    <= 1'b1;
            ahead_valid_q <= 1'b0;
          end else if (!ahead_valid_q && !wb_q.cyc && len_q == '0 &&
                       (!tx_valid_q || tx_ready_i)) begin
            tx_data_q  <= uart_dbg_pkg::CHR_EOT;
            tx_valid_q <= 1'b1;
            state_q    <= uart_dbg_pkg::SEND_EOT;
          end
        end
        uart_dbg_pkg::SEND_EOT, uart_dbg_pkg::EXEC: begin
          if (tx_fire) begin
            state_q <= uart_dbg_pkg::IDLE;
          end
        end
        default: state_q <= uart_dbg_pkg::IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign tx_byte_o = '{valid: tx_valid_q, data: tx_data_q};
  assign wb_req_o  = wb_q;

  // Entry is reported as the host takes the ACK of an EXEC
  assign exec_o = '{valid: (state_q == uart_dbg_pkg::EXEC) && tx_fire, entry: addr_q};

endmodule

`default_nettype wire

// ==== source/dbg_scratch_mem.sv ====
// Byte-wide scratch RAM behind a Wishbone classic slave port, one-cycle ack
`timescale 1ns/1ps
`default_nettype none

module dbg_scratch_mem #(
  parameter int unsigned MemAddrBits = 10
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  uart_dbg_pkg::wb_req_t wb_req_i,
  output uart_dbg_pkg::wb_rsp_t wb_rsp_o
);

  localparam int unsigned Depth = 2 ** MemAddrBits;

  logic [7:0]             mem_q [Depth];
  logic                   ack_q;
  logic [7:0]             rdata_q;
  logic [MemAddrBits-1:0] addr;
  logic                   access;

  // Upper address bits ignored, so accesses wrap
  assign addr = wb_req_i.adr[MemAddrBits-1:0];

  // One access per strobe; ack high blocks a second one
  assign access = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access && wb_req_i.we) begin
      mem_q[addr] <= wb_req_i.dat;
    end
    if (access) begin
      rdata_q <= mem_q[addr];
    end
  end

  assign wb_rsp_o = '{ack: ack_q, dat: rdata_q};

endmodule

`default_nettype wire

// ==== source/uart_dbg_top.sv ====
// UART debug bridge top; joins receiver, transmitter, protocol engine and scratch RAM
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_top #(
  parameter int unsigned ClksPerBit  = 16,
  parameter int unsigned MemAddrBits = 10
) (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                uart_rx_i,
  output logic                uart_tx_o,
  output uart_dbg_pkg::exec_t exec_o
);

  uart_dbg_pkg::byte_strm_t rx_byte;
  uart_dbg_pkg::byte_strm_t tx_byte;
  logic                     tx_ready;
  uart_dbg_pkg::wb_req_t    wb_req;
  uart_dbg_pkg::wb_rsp_t    wb_rsp;

  ////////////////////////////////////////////////////////////////////////////
  // Serial line
  ////////////////////////////////////////////////////////////////////////////

  uart_rx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_rx (
    .clk    ( clk       ),
    .rst_i  ( rst_i     ),
    .rxd_i  ( uart_rx_i ),
    .byte_o ( rx_byte   )
  );

  uart_tx #(
    .ClksPerBit ( ClksPerBit )
  ) i_uart_tx (
    .clk     ( clk       ),
    .rst_i   ( rst_i     ),
    .byte_i  ( tx_byte   ),
    .ready_o ( tx_ready  ),
    .txd_o   ( uart_tx_o )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Engine and memory
  ////////////////////////////////////////////////////////////////////////////

  dbg_cmd_fsm i_dbg_cmd_fsm (
    .clk        ( clk      ),
    .rst_i      ( rst_i    ),
    .rx_byte_i  ( rx_byte  ),
    .tx_byte_o  ( tx_byte  ),
    .tx_ready_i ( tx_ready ),
    .wb_req_o   ( wb_req   ),
    .wb_rsp_i   ( wb_rsp   ),
    .exec_o     ( exec_o   )
  );

  dbg_scratch_mem #(
    .MemAddrBits ( MemAddrBits )
  ) i_dbg_scratch_mem (
    .clk      ( clk    ),
    .rst_i    ( rst_i  ),
    .wb_req_i ( wb_req ),
    .wb_rsp_o ( wb_rsp )
  );

endmodule

`default_nettype wire

// ==== verif/clk_gen.sv ====
// Testbench clock and synchronous reset source; reset is held for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int unsigned PeriodNs    = 40,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk,
  output logic rst_o
);

  initial begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== verif/uart_dbg_properties.sv ====
// Wishbone, transmit handshake and exec pulse checks, bound into the protocol engine
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_properties (
  input logic                     clk,
  input logic                     rst_i,
  input uart_dbg_pkg::byte_strm_t tx_byte_i,
  input logic                     tx_ready_i,
  input uart_dbg_pkg::wb_req_t    wb_req_i,
  input uart_dbg_pkg::wb_rsp_t    wb_rsp_i,
  input uart_dbg_pkg::exec_t      exec_i
);

  // Read back by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone classic
  ////////////////////////////////////////////////////////////////////////////

  stb_needs_cyc: assert property (@(posedge clk) disable iff (rst_i)
    wb_req_i.stb |-> wb_req_i.cyc)
    else begin
      $error("wishbone stb high without cyc");
      fail_cnt++;
    end

  ack_needs_stb: assert property (@(posedge clk) disable iff (rst_i)
    wb_rsp_i.ack |-> wb_req_i.stb)
    else begin
      $error("wishbone ack high without stb");
      fail_cnt++;
    end

  // Master releases the bus for at least one cycle
  no_stb_after_ack: assert property (@(posedge clk) disable iff (rst_i)
    wb_rsp_i.ack |=> !wb_req_i.stb)
    else begin
      $error("wishbone stb still high in the cycle after ack");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // Exec and transmit
  ////////////////////////////////////////////////////////////////////////////

  exec_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
    exec_i.valid |=> !exec_i.valid)
    else begin
      $error("exec valid longer than one cycle");
      fail_cnt++;
    end

  tx_held_until_ready: assert property (@(posedge clk) disable iff (rst_i)
    (tx_byte_i.valid && !tx_ready_i) |=> (tx_byte_i.valid && $stable(tx_byte_i.data)))
    else begin
      $error("tx byte dropped or changed before ready");
      fail_cnt++;
    end

endmodule

bind dbg_cmd_fsm uart_dbg_properties u_dbg_props (
  .clk        ( clk        ),
  .rst_i      ( rst_i      ),
  .tx_byte_i  ( tx_byte_o  ),
  .tx_ready_i ( tx_ready_i ),
  .wb_req_i   ( wb_req_o   ),
  .wb_rsp_i   ( wb_rsp_i   ),
  .exec_i     ( exec_o     )
);

`default_nettype wire

// ==== verif/uart_dbg_tb.sv ====
// Table-driven testbench for the UART debug bridge; plays the host side of the serial link
`timescale 1ns/1ps
`default_nettype none

module uart_dbg_tb;

  localparam int unsigned ClksPerBit  = 16;
  localparam int unsigned MemAddrBits = 10;
  localparam int unsigned ClkPeriodNs = 40;
  localparam int unsigned FrameClks   = 10 * ClksPerBit;
  localparam int unsigned DriveDelay  = 5;
  localparam int unsigned NumTests    = 9;
  localparam int unsigned Depth       = 2 ** MemAddrBits;

  typedef enum logic [2:0] {
    KIND_CHALLENGE,
    KIND_WRITE,
    KIND_READ,
    KIND_EXEC,
    KIND_JUNK
  } test_kind_e;

  typedef struct {
    string       name;
    test_kind_e  kind;
    logic [63:0] addr;
    logic [63:0] len;
    logic [31:0] data_seed;
    logic [63:0] entry;
  } test_entry_t;

  logic                clk;
  logic                rst;
  logic                uart_rx;
  logic                uart_tx;
  uart_dbg_pkg::exec_t exec;

  test_entry_t tests [NumTests];
  logic [7:0]  ref_mem [Depth];
  integer      seed;
  int unsigned test_errs;
  int unsigned tests_passed;
  int unsigned tests_failed;
  int unsigned exec_pulses;
  logic [63:0] exec_entry;

  clk_gen #(
    .PeriodNs    ( ClkPeriodNs ),
    .ResetCycles ( 8           )
  ) i_clk_gen (
    .clk   ( clk ),
    .rst_o ( rst )
  );

  uart_dbg_top #(
    .ClksPerBit  ( ClksPerBit  ),
    .MemAddrBits ( MemAddrBits )
  ) DUT (
    .clk       ( clk     ),
    .rst_i     ( rst     ),
    .uart_rx_i ( uart_rx ),
    .uart_tx_o ( uart_tx ),
    .exec_o    ( exec    )
  );

  // Exec pulses, sampled away from the active edge
  always @(negedge clk) begin
    if (!rst && exec.valid) begin
      exec_pulses = exec_pulses + 1;
      exec_entry  = exec.entry;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host side of the serial line
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #DriveDelay;
      uart_rx = frame[i];
      repeat (ClksPerBit - 1) @(posedge clk);
    end
  endtask

  // Returns at mid stop bit, ok low on timeout or bad framing
  task automatic receive_byte(output logic [7:0] value, output bit ok,
                              input int unsigned max_clks);
    int unsigned waited;
    ok     = 1'b0;
    value  = '0;
    waited = 0;
    while (uart_tx && waited < max_clks) begin
      @(negedge clk);
      waited++;
    end
    if (uart_tx) return;
    repeat (ClksPerBit / 2) @(negedge clk);
    if (uart_tx) return;
    for (int i = 0; i < 8; i++) begin
      repeat (ClksPerBit) @(negedge clk);
      value[i] = uart_tx;
    end
    repeat (ClksPerBit) @(negedge clk);
    ok = uart_tx;
  endtask

  // Line has to stay idle for the whole window
  task automatic wait_line_quiet(input int unsigned max_clks, output bit quiet);
    quiet = 1'b1;
    repeat (max_clks) begin
      @(negedge clk);
      if (!uart_tx) quiet = 1'b0;
    end
  endtask

  task automatic check_reply(input string name, input int idx, input logic [7:0] exp_val,
                             input logic [7:0] act_val, input bit ok, input int unsigned clks);
    if (!ok) begin
      $display("ERROR %s: reply byte %0d missing or badly framed within %0d cycles",
               name, idx, clks);
      test_errs++;
    end else if (act_val !== exp_val) begin
      $display("FAIL %s: reply byte %0d expected 0x%02h actual 0x%02h",
               name, idx, exp_val, act_val);
      test_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequencing
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned header_bytes(input test_kind_e kind);
    case (kind)
      KIND_READ, KIND_WRITE: return 1 + 2 * uart_dbg_pkg::PROTO_FIELD_BYTES;
      KIND_EXEC:             return 1 + uart_dbg_pkg::PROTO_FIELD_BYTES;
      default:               return 1;
    endcase
  endfunction

  task automatic run_test(input test_entry_t t);
    logic [7:0]             hdr_q [$];
    logic [7:0]             data_q [$];
    logic [7:0]             exp_q [$];
    logic [7:0]             rx_val;
    logic [MemAddrBits-1:0] idx;
    bit                     rx_ok;
    bit                     quiet;
    int unsigned            wait_clks;
    test_errs   = 0;
    exec_pulses = 0;
    wait_clks   = (int'(t.len) + 2) * FrameClks;
    case (t.kind)
      KIND_CHALLENGE: hdr_q.push_back(uart_dbg_pkg::CHR_ACK);
      KIND_JUNK:      hdr_q.push_back(8'h55);
      KIND_READ:      hdr_q.push_back(uart_dbg_pkg::CMD_READ);
      KIND_WRITE:     hdr_q.push_back(uart_dbg_pkg::CMD_WRITE);
      default:        hdr_q.push_back(uart_dbg_pkg::CMD_EXEC);
    endcase
    if (t.kind inside {KIND_READ, KIND_WRITE, KIND_EXEC}) begin
      for (int i = 0; i < 8; i++) hdr_q.push_back(t.addr[8*i +: 8]);
    end
    if (t.kind inside {KIND_READ, KIND_WRITE}) begin
      for (int i = 0; i < 8; i++) hdr_q.push_back(t.len[8*i +: 8]);
    end
    // Expected replies follow the protocol, data from the reference memory
    if (t.kind != KIND_JUNK) exp_q.push_back(uart_dbg_pkg::CHR_ACK);
    if (t.kind == KIND_WRITE) begin
      seed = seed ^ t.data_seed;
      for (int i = 0; i < int'(t.len); i++) begin
        idx = MemAddrBits'(t.addr + 64'(i));
        data_q.push_back(8'($random(seed)));
        ref_mem[idx] = data_q[i];
      end
    end
    if (t.kind == KIND_READ) begin
      for (int i = 0; i < int'(t.len); i++) begin
        idx = MemAddrBits'(t.addr + 64'(i));
        exp_q.push_back(ref_mem[idx]);
      end
    end
    if (t.kind inside {KIND_READ, KIND_WRITE}) exp_q.push_back(uart_dbg_pkg::CHR_EOT);

    foreach (hdr_q[i]) send_byte(hdr_q[i]);
    if (exp_q.size() != 0) begin
      receive_byte(rx_val, rx_ok, wait_clks);
      check_reply(t.name, 0, exp_q[0], rx_val, rx_ok, wait_clks);
      fork
        begin
          foreach (data_q[i]) send_byte(data_q[i]);
        end
        begin
          for (int i = 1; i < exp_q.size(); i++) begin
            receive_byte(rx_val, rx_ok, wait_clks);
            check_reply(t.name, i, exp_q[i], rx_val, rx_ok, wait_clks);
            if (!rx_ok) break;
          end
        end
      join
    end
    // No byte may follow the last expected one
    wait_line_quiet(2 * FrameClks, quiet);
    if (!quiet) begin
      $display("ERROR %s: unexpected extra reply on the serial line", t.name);
      test_errs++;
    end
    if (t.kind == KIND_EXEC) begin
      if (exec_pulses != 1) begin
        $display("FAIL %s: exec pulses expected 1 actual %0d", t.name, exec_pulses);
        test_errs++;
      end else if (exec_entry !== t.entry) begin
        $display("FAIL %s: exec entry expected 0x%016h actual 0x%016h",
                 t.name, t.entry, exec_entry);
        test_errs++;
      end
    end else if (exec_pulses != 0) begin
      $display("FAIL %s: exec pulses expected 0 actual %0d", t.name, exec_pulses);
      test_errs++;
    end
    if (test_errs == 0) begin
      $display("PASS %s", t.name);
      tests_passed++;
    end else begin
      $display("FAIL %s: %0d check(s) failed", t.name, test_errs);
      tests_failed++;
    end
  endtask

  task automatic watchdog(input longint unsigned limit_ns);
    #(limit_ns);
    $display("Watchdog expired after %0d ns, tests did not finish", limit_ns);
    $display("Simulation FAILED");
    $finish;
  endtask

  initial begin
    longint unsigned limit_ns;
    int unsigned     assert_fails;
    uart_rx      = 1'b1;
    seed         = 32'h178042b6;
    tests_passed = 0;
    tests_failed = 0;
    exec_pulses  = 0;
    exec_entry   = '0;
    tests[0] = '{"ack_challenge", KIND_CHALLENGE, 64'h0, 64'h0, 32'h0, 64'h0};
    tests[1] = '{"write_16", KIND_WRITE, 64'h40, 64'd16, 32'h0, 64'h0};
    tests[2] = '{"read_16", KIND_READ, 64'h40, 64'd16, 32'h0, 64'h0};
    tests[3] = '{"wrap_write", KIND_WRITE, 64'h3fe, 64'd4, 32'h1, 64'h0};
    tests[4] = '{"wrap_read", KIND_READ, 64'h0, 64'd2, 32'h0, 64'h0};
    tests[5] = '{"zero_len_read", KIND_READ, 64'h40, 64'd0, 32'h0, 64'h0};
    tests[6] = '{"exec_entry", KIND_EXEC, 64'h0000_0000_8000_1234, 64'h0, 32'h0,
                 64'h0000_0000_8000_1234};
    tests[7] = '{"junk_byte", KIND_JUNK, 64'h0, 64'h0, 32'h0, 64'h0};
    tests[8] = '{"challenge_after_junk", KIND_CHALLENGE, 64'h0, 64'h0, 32'h0, 64'h0};

    // Frames per test, two quiet frames each, plus ten frames of margin
    limit_ns = (10 + 2 * NumTests) * FrameClks * ClkPeriodNs;
    foreach (tests[i]) begin
      limit_ns += longint'(header_bytes(tests[i].kind) + int'(tests[i].len) + 2) *
                  FrameClks * ClkPeriodNs;
    end
    fork
      watchdog(limit_ns);
    join_none

    wait (!rst);
    repeat (4) @(posedge clk);
    foreach (tests[i]) run_test(tests[i]);

    assert_fails = DUT.i_dbg_cmd_fsm.u_dbg_props.fail_cnt;
    $display("Tests run %0d, passed %0d, failed %0d, assertion failures %0d",
             NumTests, tests_passed, tests_failed, assert_fails);
    if (tests_failed == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/uart_dbg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/dbg_cmd_fsm.sv
source/dbg_scratch_mem.sv
source/uart_dbg_top.sv
verif/clk_gen.sv
verif/uart_dbg_properties.sv
verif/uart_dbg_tb.sv

// ==== Makefile ====
# Verilator build and run for the UART debug bridge testbench

VERILATOR ?= verilator
TOP       ?= uart_dbg_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
